// ==== cnn_loader.f ====
+incdir+common
common/cnn_loader_pkg.sv
loader/preload_store.sv
loader/load_sequencer.sv
src/cnn_loader_top.sv
sim/cnn_loader_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f cnn_loader.f --top-module cnn_loader_tb

out=$(./obj_dir/Vcnn_loader_tb)
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// ==== fm.mem ====
// one 16-bit hex word per line, feature map address 0 upward
a3c1
5e27
0f92
7b44
c815
2d6e
91a0
46fb
e03c
1b87
6cd2
f459
3a0e
8861
d7b3
25c8
7f1d
b2e6
0c4a
96f3
4e58
e1a9
5307
c96c
1ad5
6f3e
a082
3bc7
ed14
7269
0895
d4fa

// ==== weight.mem ====
// one 16-bit hex word per line, kernels 0 to 3 with 8 words each
0011
00f2
ff3c
0047
fe98
0105
0076
ffd1
0123
fec4
0031
0f0a
ff87
0062
00e9
ff15
0a4b
0019
fdc6
0238
007d
ff4e
0190
fe2b
0056
0cbe
ff03
00a1
0e77
fd92
0014
03e8

// ==== bias.mem ====
// one 16-bit hex bias word per line, kernels 0 to 3
0100
ff80
0033
fe0a

// ==== sim/cnn_loader_tb.sv ====
`timescale 1ns/1ps
`include "cnn_loader_defines.svh"

module cnn_loader_tb;

    import cnn_loader_pkg::*;

    localparam int KW          = `KERNEL_WORDS;
    localparam int WT_DEPTH    = `WEIGHT_SLOT1_BASE + `KERNEL_WORDS;  // top of slot 1
    localparam int NUM_OPS     = 20;
    localparam int CYCLE_LIMIT = 4 * (`FM_WORDS + NUM_OPS * (`KERNEL_WORDS + 8));

    logic         clk;
    logic         rst;
    load_req_t    req;
    load_status_t status;
    ram_wr_t      fm_wr;
    ram_wr_t      weight_wr;
    ram_wr_t      bias_wr;

    // request fields, driven separately so both engines can be busy at once
    logic                   upd_kernel;
    logic                   upd_slot;
    logic [`TRANS_ID_W-1:0] upd_id;
    logic                   wr_fm;
    logic [`DATA_W-1:0]     wr_data;
    logic [`FM_ADDR_W-1:0]  wr_addr;

    logic [`DATA_W-1:0] fm_file   [0:`FM_WORDS-1];
    logic [`DATA_W-1:0] pool_file [0:`KERNEL_NUM*KW-1];
    logic [`DATA_W-1:0] bias_file [0:`KERNEL_NUM-1];

    // model contents and mirrors built from observed strobes
    logic [`DATA_W-1:0] fm_exp   [0:`FM_WORDS-1];
    logic [`DATA_W-1:0] fm_mir   [0:`FM_WORDS-1];
    logic [`DATA_W-1:0] wt_exp   [0:WT_DEPTH-1];
    logic [`DATA_W-1:0] wt_mir   [0:WT_DEPTH-1];
    logic [`DATA_W-1:0] bias_exp [0:1];
    logic [`DATA_W-1:0] bias_mir [0:1];

    ram_wr_t fm_q[$];    // strobes still expected, in order
    ram_wr_t wt_q[$];
    ram_wr_t bias_q[$];

    int                     err_cnt;
    int                     check_cnt;
    int                     cyc = 0;
    int                     next_kernel;
    logic [`TRANS_ID_W-1:0] last_id;
    logic                   any_update;

    always_comb begin
        req.update_kernel = upd_kernel;
        req.kernel_slot   = upd_slot;
        req.trans_id      = upd_id;
        req.write_fm      = wr_fm;
        req.fm_data       = wr_data;
        req.fm_addr       = wr_addr;
    end

    cnn_loader_top cnn_loader_top_i (
        .clk(clk), .rst(rst), .req(req), .status(status),
        .fm_wr(fm_wr), .weight_wr(weight_wr), .bias_wr(bias_wr)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    //////////////////////////////
    // helpers and compare tasks
    //////////////////////////////

    function automatic ram_wr_t make_wr(input int addr, input logic [`DATA_W-1:0] data);
        make_wr.en   = 1'b1;
        make_wr.addr = `FM_ADDR_W'(addr);
        make_wr.data = data;
    endfunction

    function automatic ram_wr_t en_only(input logic en);
        en_only    = '0;
        en_only.en = en;
    endfunction

    function automatic load_status_t make_status(input logic init, input logic fmd,
                                                 input logic kd, input logic [3:0] id);
        make_status.init_done     = init;
        make_status.fm_done       = fmd;
        make_status.kernel_done   = kd;
        make_status.done_trans_id = id;
    endfunction

    function automatic load_status_t kernel_view(input load_status_t s);
        kernel_view         = s;
        kernel_view.fm_done = 1'b0;   // the fm path runs on its own
    endfunction

    function automatic load_status_t fm_view(input load_status_t s);
        fm_view               = s;
        fm_view.kernel_done   = 1'b0;
        fm_view.done_trans_id = '0;
    endfunction

    task automatic check_wr(input string name, input ram_wr_t exp, input ram_wr_t act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display({"[FAIL] %s: expected en=%0b addr=%0h data=%0h,",
                      " actual en=%0b addr=%0h data=%0h"},
                     name, exp.en, exp.addr, exp.data, act.en, act.addr, act.data);
        end
    endtask

    task automatic check_status(input string name, input load_status_t exp,
                                input load_status_t act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display({"[FAIL] %s: expected init=%0b fm=%0b kernel=%0b id=%0h,",
                      " actual init=%0b fm=%0b kernel=%0b id=%0h"},
                     name, exp.init_done, exp.fm_done, exp.kernel_done, exp.done_trans_id,
                     act.init_done, act.fm_done, act.kernel_done, act.done_trans_id);
        end
    endtask

    task automatic check_ports(input string name, input logic en);
        check_wr({name, " fm"}, en_only(en), en_only(fm_wr.en));
        check_wr({name, " weight"}, en_only(en), en_only(weight_wr.en));
        check_wr({name, " bias"}, en_only(en), en_only(bias_wr.en));
        check_status(name, '0, status);
    endtask

    task automatic check_drained(input string name, input int pending);
        if (pending != 0) begin
            err_cnt++;
            $display("%s finished with %0d expected writes never seen", name, pending);
        end
    endtask

    task automatic compare_buffers(input string name);
        int i;
        for (i = 0; i < `FM_WORDS; i++)
            check_wr({name, " fm buffer"}, make_wr(i, fm_exp[i]), make_wr(i, fm_mir[i]));
        for (i = 0; i < WT_DEPTH; i++)
            check_wr({name, " weight buffer"}, make_wr(i, wt_exp[i]), make_wr(i, wt_mir[i]));
        for (i = 0; i < 2; i++)
            check_wr({name, " bias buffer"}, make_wr(i, bias_exp[i]), make_wr(i, bias_mir[i]));
    endtask

    // pop the expected strobe for a port, then fold the observed one into its mirror
    task automatic take_write(input int port, input string name, input ram_wr_t act);
        ram_wr_t exp;
        int      left;
        case (port)
            0: left = fm_q.size();
            1: left = wt_q.size();
            default: left = bias_q.size();
        endcase
        if (left == 0) begin
            err_cnt++;
            $display("unexpected %s at address %0h", name, act.addr);
        end else begin
            case (port)
                0: exp = fm_q.pop_front();
                1: exp = wt_q.pop_front();
                default: exp = bias_q.pop_front();
            endcase
            check_wr(name, exp, act);
        end
        case (port)
            0: if (act.addr < `FM_WORDS) fm_mir[act.addr[4:0]] = act.data;
            1: if (act.addr < WT_DEPTH) wt_mir[act.addr[4:0]] = act.data;
            default: if (act.addr < 2) bias_mir[act.addr[0]] = act.data;
        endcase
    endtask

    // outputs settle after the rising edge, so look at them mid-cycle
    always @(negedge clk) begin
        if (fm_wr.en) take_write(0, "fm write", fm_wr);
        if (weight_wr.en) take_write(1, "weight write", weight_wr);
        if (bias_wr.en) take_write(2, "bias write", bias_wr);
    end

    //////////////////////////////
    // request sequences
    //////////////////////////////

    task automatic issue_update(input logic slot, input logic [`TRANS_ID_W-1:0] id);
        int base;
        int i;
        base = slot ? `WEIGHT_SLOT1_BASE : `WEIGHT_SLOT0_BASE;
        for (i = 0; i < KW; i++) begin
            wt_q.push_back(make_wr(base + i, pool_file[next_kernel*KW + i]));
            wt_exp[base + i] = pool_file[next_kernel*KW + i];
        end
        bias_q.push_back(make_wr(slot, bias_file[next_kernel]));
        bias_exp[slot] = bias_file[next_kernel];
        next_kernel = (next_kernel + 1) % `KERNEL_NUM;
        @(posedge clk);
        upd_kernel <= 1'b1;
        upd_slot   <= slot;
        upd_id     <= id;
        @(negedge clk);
        while (status.kernel_done) @(negedge clk);    // old completion clears on start
        while (!status.kernel_done) @(negedge clk);
        check_status("kernel update done", make_status(1'b1, 1'b0, 1'b1, id),
                     kernel_view(status));
        check_drained("kernel update", wt_q.size() + bias_q.size());
        @(posedge clk);
        upd_kernel <= 1'b0;
        last_id    = id;
        any_update = 1'b1;
    endtask

    // same id as the last completion, must be ignored
    task automatic issue_repeat_update(input logic slot);
        @(posedge clk);
        upd_kernel <= 1'b1;
        upd_slot   <= slot;
        upd_id     <= last_id;
        repeat (KW + 4) @(negedge clk);
        check_status("repeated trans_id", make_status(1'b1, 1'b0, any_update, last_id), status);
        @(posedge clk);
        upd_kernel <= 1'b0;
    endtask

    task automatic issue_fm_write(input int addr, input logic [`DATA_W-1:0] data);
        fm_q.push_back(make_wr(addr, data));
        fm_exp[addr] = data;
        @(posedge clk);
        wr_fm   <= 1'b1;
        wr_addr <= `FM_ADDR_W'(addr);
        wr_data <= data;
        @(negedge clk);
        while (!status.fm_done) @(negedge clk);
        check_status("fm write done", make_status(1'b1, 1'b1, 1'b0, '0), fm_view(status));
        check_drained("fm write", fm_q.size());
        @(posedge clk);
        wr_fm <= 1'b0;
        @(negedge clk);
        while (status.fm_done) @(negedge clk);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int                     op;
        int                     kind;
        int                     i;
        logic                   slot;
        logic [`TRANS_ID_W-1:0] id;
        int                     addr;
        logic [`DATA_W-1:0]     data;
        void'($urandom(32'h762ad0a8));
        err_cnt     = 0;
        check_cnt   = 0;
        next_kernel = 2;      // kernels 0 and 1 go in at init
        last_id     = '0;
        any_update  = 1'b0;
        rst        <= 1'b1;
        upd_kernel <= 1'b0;
        upd_slot   <= 1'b0;
        upd_id     <= '0;
        wr_fm      <= 1'b0;
        wr_data    <= '0;
        wr_addr    <= '0;
        $readmemh("fm.mem", fm_file);
        $readmemh("weight.mem", pool_file);
        $readmemh("bias.mem", bias_file);
        for (i = 0; i < WT_DEPTH; i++) begin
            wt_exp[i] = '0;
            wt_mir[i] = '0;
        end
        for (i = 0; i < `FM_WORDS; i++) begin
            fm_exp[i] = fm_file[i];
            fm_mir[i] = '0;
            fm_q.push_back(make_wr(i, fm_file[i]));
        end
        for (i = 0; i < 2 * KW; i++) begin
            addr = (i < KW) ? `WEIGHT_SLOT0_BASE + i : `WEIGHT_SLOT1_BASE + i - KW;
            wt_exp[addr] = pool_file[i];
            wt_q.push_back(make_wr(addr, pool_file[i]));
        end
        for (i = 0; i < 2; i++) begin
            bias_exp[i] = bias_file[i];
            bias_mir[i] = '0;
            bias_q.push_back(make_wr(i, bias_file[i]));
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_ports("in reset", 1'b0);
        @(posedge clk);
        rst <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_ports("before init streams", 1'b0);
        end
        @(negedge clk);
        check_ports("init streams start", 1'b1);   // two cycles after rst falls

        while (!status.init_done) @(negedge clk);
        check_drained("init", fm_q.size() + wt_q.size() + bias_q.size());
        check_status("init done", make_status(1'b1, 1'b0, 1'b0, '0), status);
        compare_buffers("init");

        for (op = 0; op < NUM_OPS; op++) begin
            kind = (op < 5) ? op : $urandom % 5;   // every kind at least once
            slot = 1'($urandom);
            id   = `TRANS_ID_W'($urandom);
            if (id == last_id) id = id + 1'b1;
            addr = $urandom % `FM_WORDS;
            data = `DATA_W'($urandom);
            case (kind)
                0, 1: issue_update(slot, id);
                2: issue_fm_write(addr, data);
                3: fork
                    issue_update(slot, id);
                    issue_fm_write(addr, data);
                join
                default: issue_repeat_update(slot);
            endcase
        end

        repeat (4) @(negedge clk);   // catch stray writes
        check_drained("run", fm_q.size() + wt_q.size() + bias_q.size());
        compare_buffers("final");
        $display("checks: %0d  errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("checks: %0d  errors: %0d", check_cnt, err_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

// ==== src/cnn_loader_top.sv ====
`timescale 1ns/1ps
`include "cnn_loader_defines.svh"

module cnn_loader_top (
    input  logic                         clk,
    input  logic                         rst,
    input  cnn_loader_pkg::load_req_t    req,
    output cnn_loader_pkg::load_status_t status,
    output cnn_loader_pkg::ram_wr_t      fm_wr,
    output cnn_loader_pkg::ram_wr_t      weight_wr,
    output cnn_loader_pkg::ram_wr_t      bias_wr
);

    // store read side
    logic                   fm_rd_en;
    logic [`FM_IDX_W-1:0]   fm_rd_addr;
    logic [`DATA_W-1:0]     fm_rd_data;
    logic                   weight_rd_en;
    logic [`POOL_IDX_W-1:0] weight_rd_addr;
    logic [`DATA_W-1:0]     weight_rd_data;
    logic                   bias_rd_en;
    logic [`KNUM_W-1:0]     bias_rd_addr;
    logic [`DATA_W-1:0]     bias_rd_data;

    preload_store preload_store_i (
        .clk(clk),
        .fm_rd_en(fm_rd_en), .fm_rd_addr(fm_rd_addr), .fm_rd_data(fm_rd_data),
        .weight_rd_en(weight_rd_en), .weight_rd_addr(weight_rd_addr),
        .weight_rd_data(weight_rd_data),
        .bias_rd_en(bias_rd_en), .bias_rd_addr(bias_rd_addr), .bias_rd_data(bias_rd_data)
    );

    load_sequencer load_sequencer_i (
        .clk(clk), .rst(rst), .req(req),
        .fm_rd_data(fm_rd_data), .weight_rd_data(weight_rd_data), .bias_rd_data(bias_rd_data),
        .fm_rd_en(fm_rd_en), .fm_rd_addr(fm_rd_addr),
        .weight_rd_en(weight_rd_en), .weight_rd_addr(weight_rd_addr),
        .bias_rd_en(bias_rd_en), .bias_rd_addr(bias_rd_addr),
        .status(status),
        .fm_wr(fm_wr), .weight_wr(weight_wr), .bias_wr(bias_wr)
    );

endmodule

// ==== loader/load_sequencer.sv ====
`timescale 1ns/1ps
`include "cnn_loader_defines.svh"

module load_sequencer (
    input  logic                        clk,
    input  logic                        rst,
    input  cnn_loader_pkg::load_req_t   req,
    input  logic [`DATA_W-1:0]          fm_rd_data,
    input  logic [`DATA_W-1:0]          weight_rd_data,
    input  logic [`DATA_W-1:0]          bias_rd_data,
    output logic                        fm_rd_en,
    output logic [`FM_IDX_W-1:0]        fm_rd_addr,
    output logic                        weight_rd_en,
    output logic [`POOL_IDX_W-1:0]      weight_rd_addr,
    output logic                        bias_rd_en,
    output logic [`KNUM_W-1:0]          bias_rd_addr,
    output cnn_loader_pkg::load_status_t status,
    output cnn_loader_pkg::ram_wr_t     fm_wr,
    output cnn_loader_pkg::ram_wr_t     weight_wr,
    output cnn_loader_pkg::ram_wr_t     bias_wr
);

    import cnn_loader_pkg::*;

    localparam int KW       = `KERNEL_WORDS;
    localparam int KW_IDX_W = $clog2(`KERNEL_WORDS);
    localparam int WA_W     = `WEIGHT_ADDR_W;
    localparam int AW       = `FM_ADDR_W;
    localparam int PW       = `POOL_IDX_W;
    localparam int KNW      = `KNUM_W;
    localparam int INIT_BIAS = 2;                           // biases 0 and 1
    localparam logic [KNW-1:0] FIRST_UPD_KERNEL = KNW'(2);  // 0 and 1 go in at init

    init_state_e init_state;
    kupd_state_e kupd_state;

    logic [`FM_IDX_W:0]        fm_cnt;
    logic [KW_IDX_W+1:0]       wt_cnt;    // up to 2 kernels at init
    logic [1:0]                bias_cnt;
    logic [KNW-1:0]            next_kernel;
    logic [`TRANS_ID_W-1:0]    done_id_q;
    logic [`TRANS_ID_W-1:0]    kupd_id_q;

    // issue stage, travels with the read
    logic [WA_W-1:0]           wt_wa;
    logic                      bias_wa;
    // data stage, lines up with the store output
    logic                      fm_we_q, wt_we_q, bias_we_q;
    logic [AW-1:0]             fm_wa_q;
    logic [WA_W-1:0]           wt_wa_q;
    logic                      bias_wa_q;

    logic                      write_fm_q;
    logic                      fm_done_q;
    ram_wr_t                   fm_dir_q;  // single word from a request

    logic init_loading, init_last;
    logic fm_issue, wt_init_issue, bias_init_issue;
    logic kupd_start, wt_upd_issue, kupd_last;
    logic fm_rise;

    function automatic logic [WA_W-1:0] slot_base(input logic slot);
        slot_base = slot ? WA_W'(`WEIGHT_SLOT1_BASE) : WA_W'(`WEIGHT_SLOT0_BASE);
    endfunction

    //////////////////////////////
    // issue conditions
    //////////////////////////////

    assign init_loading    = (init_state == INIT_LOAD);
    assign fm_issue        = init_loading && (fm_cnt < `FM_WORDS);
    assign wt_init_issue   = init_loading && (wt_cnt < 2 * KW);
    assign bias_init_issue = init_loading && (bias_cnt < INIT_BIAS);
    // all counters spent and last reads already in the data stage
    assign init_last = init_loading && (fm_cnt == `FM_WORDS) && (wt_cnt == 2 * KW)
                       && (bias_cnt == INIT_BIAS) && !fm_rd_en && !weight_rd_en && !bias_rd_en;

    assign kupd_start = req.update_kernel && !init_loading && (kupd_state != KUPD_RUN)
                        && (req.trans_id != done_id_q);
    assign wt_upd_issue = (kupd_state == KUPD_RUN) && (wt_cnt < KW);
    assign kupd_last    = (kupd_state == KUPD_RUN) && (wt_cnt == KW) && !weight_rd_en;

    assign fm_rise = !init_loading && req.write_fm && !write_fm_q;

    //////////////////////////////
    // init FSM and stream counters
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_state   <= INIT_LOAD;
            fm_cnt       <= '0;
            wt_cnt       <= '0;
            bias_cnt     <= '0;
            fm_rd_en     <= 1'b0;
            weight_rd_en <= 1'b0;
            bias_rd_en   <= 1'b0;
        end else begin
            fm_rd_en     <= fm_issue;
            weight_rd_en <= wt_init_issue | kupd_start | wt_upd_issue;
            bias_rd_en   <= bias_init_issue | kupd_start;  // one bias per update
            if (fm_issue) begin
                fm_cnt <= fm_cnt + 1'b1;
            end
            if (kupd_start) begin
                wt_cnt <= 1;                 // word 0 goes out with the start
            end else if (wt_init_issue || wt_upd_issue) begin
                wt_cnt <= wt_cnt + 1'b1;
            end
            if (bias_init_issue) begin
                bias_cnt <= bias_cnt + 1'b1;
            end
            if (init_last) begin
                init_state <= INIT_DONE;
            end
        end
    end

    //////////////////////////////
    // kernel update FSM
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kupd_state  <= KUPD_IDLE;
            next_kernel <= FIRST_UPD_KERNEL;
            done_id_q   <= '0;
        end else begin
            case (kupd_state)
                KUPD_IDLE, KUPD_DONE: begin
                    if (kupd_start) kupd_state <= KUPD_RUN;
                end
                KUPD_RUN: begin
                    if (kupd_last) begin
                        kupd_state  <= KUPD_DONE;
                        done_id_q   <= kupd_id_q;
                        next_kernel <= (next_kernel == KNW'(`KERNEL_NUM - 1)) ? '0
                                                                               : next_kernel + 1'b1;
                    end
                end
                default: kupd_state <= KUPD_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // feature-map write path
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            write_fm_q <= 1'b0;
            fm_done_q  <= 1'b0;
            fm_dir_q   <= '0;
        end else begin
            write_fm_q  <= req.write_fm;
            fm_dir_q.en <= fm_rise;
            if (fm_rise) begin
                fm_dir_q.addr <= req.fm_addr;
                fm_dir_q.data <= req.fm_data;
            end
            if (!req.write_fm) begin
                fm_done_q <= 1'b0;
            end else if (fm_dir_q.en) begin
                fm_done_q <= 1'b1;   // cycle after the strobe
            end
        end
    end

    // data stage enables
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fm_we_q   <= 1'b0;
            wt_we_q   <= 1'b0;
            bias_we_q <= 1'b0;
        end else begin
            fm_we_q   <= fm_rd_en;
            wt_we_q   <= weight_rd_en;
            bias_we_q <= bias_rd_en;
        end
    end

    //////////////////////////////
    // read and target addresses
    //////////////////////////////

    always_ff @(posedge clk) begin
        fm_wa_q   <= AW'(fm_rd_addr);
        wt_wa_q   <= wt_wa;
        bias_wa_q <= bias_wa;
        if (fm_issue) begin
            fm_rd_addr <= fm_cnt[`FM_IDX_W-1:0];
        end
        if (wt_init_issue) begin
            weight_rd_addr <= PW'(wt_cnt);
            wt_wa <= slot_base(wt_cnt[KW_IDX_W]) + WA_W'(wt_cnt[KW_IDX_W-1:0]);
        end else if (kupd_start) begin
            weight_rd_addr <= {next_kernel, {KW_IDX_W{1'b0}}};  // kernel start in pool
            wt_wa          <= slot_base(req.kernel_slot);
            kupd_id_q      <= req.trans_id;
        end else if (wt_upd_issue) begin
            weight_rd_addr <= weight_rd_addr + 1'b1;
            wt_wa          <= wt_wa + 1'b1;
        end
        if (bias_init_issue) begin
            bias_rd_addr <= KNW'(bias_cnt);
            bias_wa      <= bias_cnt[0];
        end else if (kupd_start) begin
            bias_rd_addr <= next_kernel;
            bias_wa      <= req.kernel_slot;  // bias entry follows the slot
        end
    end

    // write ports and status
    always_comb begin
        fm_wr = fm_dir_q;
        if (fm_we_q) begin
            fm_wr.en   = 1'b1;
            fm_wr.addr = fm_wa_q;
            fm_wr.data = fm_rd_data;
        end
        weight_wr.en   = wt_we_q;
        weight_wr.addr = AW'(wt_wa_q);
        weight_wr.data = weight_rd_data;
        bias_wr.en     = bias_we_q;
        bias_wr.addr   = AW'(bias_wa_q);
        bias_wr.data   = bias_rd_data;

        status.init_done     = (init_state == INIT_DONE);
        status.fm_done       = fm_done_q;
        status.kernel_done   = (kupd_state == KUPD_DONE);
        status.done_trans_id = done_id_q;
    end

endmodule

// ==== loader/preload_store.sv ====
`timescale 1ns/1ps
`include "cnn_loader_defines.svh"

module preload_store (
    input  logic                   clk,
    input  logic                   fm_rd_en,
    input  logic [`FM_IDX_W-1:0]   fm_rd_addr,
    input  logic                   weight_rd_en,
    input  logic [`POOL_IDX_W-1:0] weight_rd_addr,
    input  logic                   bias_rd_en,
    input  logic [`KNUM_W-1:0]     bias_rd_addr,
    output logic [`DATA_W-1:0]     fm_rd_data,
    output logic [`DATA_W-1:0]     weight_rd_data,
    output logic [`DATA_W-1:0]     bias_rd_data
);

    logic [`DATA_W-1:0] fm_mem     [0:`FM_WORDS-1];
    logic [`DATA_W-1:0] weight_mem [0:`POOL_WORDS-1];   // kernels back to back
    logic [`DATA_W-1:0] bias_mem   [0:`KERNEL_NUM-1];   // one per kernel

    initial begin
        $readmemh("fm.mem", fm_mem);
        $readmemh("weight.mem", weight_mem);
        $readmemh("bias.mem", bias_mem);
    end

    // registered read ports, data one cycle after the strobe
    always_ff @(posedge clk) begin
        if (fm_rd_en) begin
            fm_rd_data <= fm_mem[fm_rd_addr];
        end
        if (weight_rd_en) begin
            weight_rd_data <= weight_mem[weight_rd_addr];
        end
        if (bias_rd_en) begin
            bias_rd_data <= bias_mem[bias_rd_addr];
        end
    end

endmodule

// ==== common/cnn_loader_pkg.sv ====
`include "cnn_loader_defines.svh"

package cnn_loader_pkg;

    ////////////////////////////////
    // buffer write port
    ////////////////////////////////

    // narrower buffers take the low address bits
    typedef struct packed {
        logic                  en;
        logic [`FM_ADDR_W-1:0] addr;
        logic [`DATA_W-1:0]    data;
    } ram_wr_t;

    ////////////////////////////////
    // requests and status
    ////////////////////////////////

    typedef struct packed {
        logic                   update_kernel;  // level, held until kernel_done
        logic                   kernel_slot;
        logic [`TRANS_ID_W-1:0] trans_id;
        logic                   write_fm;       // level, held until fm_done
        logic [`DATA_W-1:0]     fm_data;
        logic [`FM_ADDR_W-1:0]  fm_addr;
    } load_req_t;

    typedef struct packed {
        logic                   init_done;
        logic                   fm_done;
        logic                   kernel_done;
        logic [`TRANS_ID_W-1:0] done_trans_id;  // id of last finished update
    } load_status_t;

    ////////////////////////////////
    // sequencer states
    ////////////////////////////////

    typedef enum logic {
        INIT_LOAD,
        INIT_DONE
    } init_state_e;

    typedef enum logic [1:0] {
        KUPD_IDLE,
        KUPD_RUN,
        KUPD_DONE
    } kupd_state_e;

endpackage

// ==== common/cnn_loader_defines.svh ====
`ifndef CNN_LOADER_DEFINES_SVH
`define CNN_LOADER_DEFINES_SVH

// feature map geometry
`define FM_SIZE   4
`define FM_DEPTH  2
`define FM_WORDS  (`FM_SIZE * `FM_SIZE * `FM_DEPTH)

// kernel pool held in the preload store
`define KERNEL_WORDS (2 * 2 * `FM_DEPTH)  // 2x2 window per channel
`define KERNEL_NUM   4
`define POOL_WORDS   (`KERNEL_NUM * `KERNEL_WORDS)

// word and address widths
`define DATA_W        16
`define TRANS_ID_W    4
`define FM_ADDR_W     19
`define WEIGHT_ADDR_W 13
`define FM_IDX_W      5   // indexes FM_WORDS
`define POOL_IDX_W    5   // indexes POOL_WORDS
`define KNUM_W        2   // indexes KERNEL_NUM

// weight ram slot start addresses
`define WEIGHT_SLOT0_BASE 0
`define WEIGHT_SLOT1_BASE 16

`endif
